// File: files.f
src/conv_pkg.sv
src/kernel_weight_bank.sv
src/tap_dot_product.sv
src/channel_requant.sv
src/conv_layer.sv
tests/tb_clock_gen.sv
tests/tb_conv_layer.sv

// File: run.sh
#!/bin/sh
# Build and run the conv_layer testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_conv_layer -f files.f -o sim_conv_layer

# The simulator exits non-zero on $fatal, the log decides the result
./obj_dir/sim_conv_layer > sim.log 2>&1 || true
cat sim.log

if grep -q "Result: FAILED" sim.log; then
    exit 1
fi
grep -q "Result: PASSED" sim.log

// File: src/channel_requant.sv
`timescale 1ns/1ps

module channel_requant #(
    parameter int NUM_IN_CH     = conv_pkg::NUM_IN_CH,
    parameter int REQUANT_SHIFT = conv_pkg::REQUANT_SHIFT
) (
    input  logic            clk,
    input  logic            arst_n,
    // en delayed by one cycle, lines up with the registered partials
    input  logic            en,
    input  conv_pkg::prod_t partials [NUM_IN_CH],
    output conv_pkg::act_t  act
);

    logic signed [conv_pkg::ACC_W-1:0] acc;
    logic signed [conv_pkg::ACC_W-1:0] shifted;
    conv_pkg::act_t                    clamped;

    // Sum across input channels
    // Each partial sign-extends into the wider accumulator
    always_comb begin
        acc = '0;
        for (int i = 0; i < NUM_IN_CH; i++) begin
            acc = acc + partials[i];
        end
    end

    // Arithmetic shift, so negative sums round toward minus infinity
    assign shifted = acc >>> REQUANT_SHIFT;

    // Symmetric saturation to +-ACT_MAX
    always_comb begin
        if (shifted > conv_pkg::ACT_MAX) begin
            clamped = conv_pkg::act_t'(conv_pkg::ACT_MAX);
        end else if (shifted < -conv_pkg::ACT_MAX) begin
            // Clamp at -127 rather than -128
            clamped = conv_pkg::act_t'(-conv_pkg::ACT_MAX);
        end else begin
            // In range, low bits carry the value
            clamped = shifted[conv_pkg::ACT_W-1:0];
        end
    end

    // Pipeline stage 2
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            act <= '0;
        end else if (en) begin
            act <= clamped;
        end
    end

    // The most negative code must never leave the layer
    a_no_min_code : assert property (
        @(posedge clk) disable iff (!arst_n)
        en |=> act != conv_pkg::act_t'(-conv_pkg::ACT_MAX - 1)
    ) else $error("requant produced -128 from sum %0d", $past(acc));

endmodule

// File: src/conv_layer.sv
`timescale 1ns/1ps

module conv_layer #(
    parameter int NUM_IN_CH     = conv_pkg::NUM_IN_CH,
    parameter int NUM_OUT_CH    = conv_pkg::NUM_OUT_CH,
    parameter int REQUANT_SHIFT = conv_pkg::REQUANT_SHIFT
) (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 en,
    input  conv_pkg::in_frame_t  in_frame,
    input  logic                 weight_we,
    input  conv_pkg::weight_wr_t weight_wr,
    output logic                 out_valid,
    output conv_pkg::out_frame_t out_frame
);

    conv_pkg::window_t kernels  [NUM_OUT_CH][NUM_IN_CH];
    conv_pkg::prod_t   partials [NUM_OUT_CH][NUM_IN_CH];
    conv_pkg::act_t    acts     [NUM_OUT_CH];

    // en after stage 1, enables the requant registers
    logic en_d1;
    // en after stage 2, marks out_frame valid
    logic en_d2;

    kernel_weight_bank #(
        .NUM_IN_CH  (NUM_IN_CH),
        .NUM_OUT_CH (NUM_OUT_CH)
    ) i_weight_bank (
        .clk       (clk),
        .arst_n    (arst_n),
        .weight_we (weight_we),
        .weight_wr (weight_wr),
        .kernels   (kernels)
    );

    // Every input window meets every output channel's kernel
    for (genvar o = 0; o < NUM_OUT_CH; o++) begin : g_out
        for (genvar i = 0; i < NUM_IN_CH; i++) begin : g_in
            tap_dot_product i_dot (
                .clk    (clk),
                .arst_n (arst_n),
                .en     (en),
                .window (in_frame.ch[i]),
                .kernel (kernels[o][i]),
                .prod   (partials[o][i])
            );
        end

        // One requant unit folds the input channels of this output channel
        channel_requant #(
            .NUM_IN_CH     (NUM_IN_CH),
            .REQUANT_SHIFT (REQUANT_SHIFT)
        ) i_requant (
            .clk      (clk),
            .arst_n   (arst_n),
            .en       (en_d1),
            .partials (partials[o]),
            .act      (acts[o])
        );
    end

    // Valid tracks the frame through both stages
    // Two frames can be in flight at once
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            en_d1 <= 1'b0;
            en_d2 <= 1'b0;
        end else begin
            en_d1 <= en;
            en_d2 <= en_d1;
        end
    end

    assign out_valid = en_d2;

    // Pack channel results into the output frame
    always_comb begin
        for (int o = 0; o < NUM_OUT_CH; o++) begin
            out_frame.ch[o] = acts[o];
        end
    end

endmodule

// File: src/conv_pkg.sv
package conv_pkg;

    // Layer geometry
    parameter int NUM_IN_CH  = 8;
    parameter int NUM_OUT_CH = 8;
    parameter int NUM_TAPS   = 5;

    // Activations and weights share one signed width
    parameter int ACT_W = 8;

    // 5 products of 8x8 signed bits, worst case 5 * 128 * 128
    parameter int PROD_W = 19;

    // Sum of 8 dot products
    parameter int ACC_W = 22;

    // Requantization scale, divide by 512 rounding toward minus infinity
    parameter int REQUANT_SHIFT = 9;

    // Symmetric clamp, -128 is never produced
    parameter int ACT_MAX = 127;

    // Enough bits to name any of the 8 channels
    parameter int CH_IDX_W = 3;

    typedef logic signed [ACT_W-1:0] act_t;

    // One kernel or one input window, tap 0 is the oldest sample
    typedef struct packed {
        act_t [NUM_TAPS-1:0] tap;
    } window_t;

    // One window per input channel
    typedef struct packed {
        window_t [NUM_IN_CH-1:0] ch;
    } in_frame_t;

    // One requantized activation per output channel
    typedef struct packed {
        act_t [NUM_OUT_CH-1:0] ch;
    } out_frame_t;

    typedef logic signed [PROD_W-1:0] prod_t;

    // Single kernel write, addressed by output and input channel
    typedef struct packed {
        logic [CH_IDX_W-1:0] out_ch;
        logic [CH_IDX_W-1:0] in_ch;
        window_t             taps;
    } weight_wr_t;

endpackage

// File: src/kernel_weight_bank.sv
`timescale 1ns/1ps

module kernel_weight_bank #(
    parameter int NUM_IN_CH  = conv_pkg::NUM_IN_CH,
    parameter int NUM_OUT_CH = conv_pkg::NUM_OUT_CH
) (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 weight_we,
    input  conv_pkg::weight_wr_t weight_wr,
    output conv_pkg::window_t    kernels [NUM_OUT_CH][NUM_IN_CH]
);

    // Write address lies inside the bank
    logic addr_ok;

    assign addr_ok = (int'(weight_wr.out_ch) < NUM_OUT_CH) &&
                     (int'(weight_wr.in_ch) < NUM_IN_CH);

    // Full register file, every kernel visible to its dot-product unit at once
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            // All kernels start at zero so outputs read zero until loaded
            for (int o = 0; o < NUM_OUT_CH; o++) begin
                for (int i = 0; i < NUM_IN_CH; i++) begin
                    kernels[o][i] <= '0;
                end
            end
        end else if (weight_we && addr_ok) begin
            // One kernel per strobe
            // Windows sampled on this same edge still see the old kernel
            kernels[weight_wr.out_ch][weight_wr.in_ch] <= weight_wr.taps;
        end
    end

    // A write outside the bank would be dropped silently
    a_write_in_range : assert property (
        @(posedge clk) disable iff (!arst_n)
        weight_we |-> addr_ok
    ) else $error("kernel write to out_ch %0d in_ch %0d is outside the bank",
                  weight_wr.out_ch, weight_wr.in_ch);

endmodule

// File: src/tap_dot_product.sv
`timescale 1ns/1ps

module tap_dot_product (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              en,
    input  conv_pkg::window_t window,
    input  conv_pkg::window_t kernel,
    output conv_pkg::prod_t   prod
);

    // Full precision sum, wide enough to catch any overflow of prod
    int sum_wide;

    always_comb begin : mac
        logic signed [2*conv_pkg::ACT_W-1:0] pair;
        sum_wide = 0;
        for (int t = 0; t < conv_pkg::NUM_TAPS; t++) begin
            // 8x8 signed product fits 16 bits, even -128 * -128
            pair = $signed(window.tap[t]) * $signed(kernel.tap[t]);
            sum_wide = sum_wide + int'(pair);
        end
    end

    // Pipeline stage 1
    // Value holds while en is low, the requant stage only samples it once
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            prod <= '0;
        end else if (en) begin
            prod <= conv_pkg::prod_t'(sum_wide);
        end
    end

    // Registered result equals the full precision sum, so nothing was cut off
    a_prod_fits : assert property (
        @(posedge clk) disable iff (!arst_n)
        en |=> int'(prod) == $past(sum_wide)
    ) else $error("dot product %0d does not fit %0d bits",
                  $past(sum_wide), conv_pkg::PROD_W);

endmodule

// File: tests/conv_layer_patterns.txt
# W out_ch in_ch tap0 tap1 tap2 tap3 tap4 (hex)
# V in ch0..ch7 each tap0..tap4 (40 hex bytes), then out ch0..ch7 (8 hex bytes)
# Diagonal kernels (o+1) * (1 -2 3 -4 5)
W 0 0 01 FE 03 FC 05
W 1 1 02 FC 06 F8 0A
W 2 2 03 FA 09 F4 0F
W 3 3 04 F8 0C F0 14
W 4 4 05 F6 0F EC 19
W 5 5 06 F4 12 E8 1E
W 6 6 07 F2 15 E4 23
W 7 7 08 F0 18 E0 28
# Neighbour kernels, all taps -16
W 0 1 F0 F0 F0 F0 F0
W 1 2 F0 F0 F0 F0 F0
W 2 3 F0 F0 F0 F0 F0
W 3 4 F0 F0 F0 F0 F0
W 4 5 F0 F0 F0 F0 F0
W 5 6 F0 F0 F0 F0 F0
W 6 7 F0 F0 F0 F0 F0
W 7 0 F0 F0 F0 F0 F0
# Mixed sign arithmetic
V 64 64 64 64 64 64 64 64 64 64 64 64 64 64 64 64 64 64 64 64
  64 64 64 64 64 64 64 64 64 64 64 64 64 64 64 64 64 64 64 64
  F0 F1 F2 F2 F3 F3 F4 F5
V CE CE CE CE CE 3C 3C 3C 3C 3C CE CE CE CE CE 3C 3C 3C 3C 3C
  CE CE CE CE CE 3C 3C 3C 3C 3C CE CE CE CE CE 3C 3C 3C 3C 3C
  F6 08 F5 09 F5 09 F4 0A
V 00 00 00 00 64 00 00 00 00 64 00 00 00 00 64 00 00 00 00 64
  00 00 00 00 64 00 00 00 00 64 00 00 00 00 64 00 00 00 00 64
  FD FE FF 00 01 02 03 04
V 64 00 00 00 00 64 00 00 00 00 64 00 00 00 00 64 00 00 00 00
  64 00 00 00 00 64 00 00 00 00 64 00 00 00 00 64 00 00 00 00
  FD FD FD FD FD FE FE FE
V 64 64 64 64 64 64 64 64 64 64 64 64 64 64 64 64 64 64 64 64
  64 64 64 64 64 64 64 64 64 64 64 64 64 64 64 64 64 64 64 64
  F0 F1 F2 F2 F3 F3 F4 F5
V CE CE CE CE CE 3C 3C 3C 3C 3C CE CE CE CE CE 3C 3C 3C 3C 3C
  CE CE CE CE CE 3C 3C 3C 3C 3C CE CE CE CE CE 3C 3C 3C 3C 3C
  F6 08 F5 09 F5 09 F4 0A
V 00 00 00 00 64 00 00 00 00 64 00 00 00 00 64 00 00 00 00 64
  00 00 00 00 64 00 00 00 00 64 00 00 00 00 64 00 00 00 00 64
  FD FE FF 00 01 02 03 04
V 64 00 00 00 00 64 00 00 00 00 64 00 00 00 00 64 00 00 00 00
  64 00 00 00 00 64 00 00 00 00 64 00 00 00 00 64 00 00 00 00
  FD FD FD FD FD FE FE FE
# Diagonal kernels rewritten to all 127, neighbours unchanged
W 0 0 7F 7F 7F 7F 7F
W 1 1 7F 7F 7F 7F 7F
W 2 2 7F 7F 7F 7F 7F
W 3 3 7F 7F 7F 7F 7F
W 4 4 7F 7F 7F 7F 7F
W 5 5 7F 7F 7F 7F 7F
W 6 6 7F 7F 7F 7F 7F
W 7 7 7F 7F 7F 7F 7F
V 64 64 64 64 64 64 64 64 64 64 64 64 64 64 64 64 64 64 64 64
  64 64 64 64 64 64 64 64 64 64 64 64 64 64 64 64 64 64 64 64
  6C 6C 6C 6C 6C 6C 6C 6C
# Saturation, both signs
V 7F 7F 7F 7F 7F 7F 7F 7F 7F 7F 7F 7F 7F 7F 7F 7F 7F 7F 7F 7F
  7F 7F 7F 7F 7F 7F 7F 7F 7F 7F 7F 7F 7F 7F 7F 7F 7F 7F 7F 7F
  7F 7F 7F 7F 7F 7F 7F 7F
V 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80
  80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80
  81 81 81 81 81 81 81 81
# Clamp boundaries, shifted sums of 127, -128, 126 and -127
V 76 76 76 76 76 76 76 76 76 76 76 76 76 76 76 76 76 76 76 76
  76 76 76 76 76 76 76 76 76 76 76 76 76 76 76 76 76 76 76 76
  7F 7F 7F 7F 7F 7F 7F 7F
V 8A 8A 8A 8A 8A 8A 8A 8A 8A 8A 8A 8A 8A 8A 8A 8A 8A 8A 8A 8A
  8A 8A 8A 8A 8A 8A 8A 8A 8A 8A 8A 8A 8A 8A 8A 8A 8A 8A 8A 8A
  81 81 81 81 81 81 81 81
V 75 75 75 75 75 75 75 75 75 75 75 75 75 75 75 75 75 75 75 75
  75 75 75 75 75 75 75 75 75 75 75 75 75 75 75 75 75 75 75 75
  7E 7E 7E 7E 7E 7E 7E 7E
V 8B 8B 8B 8B 8B 8B 8B 8B 8B 8B 8B 8B 8B 8B 8B 8B 8B 8B 8B 8B
  8B 8B 8B 8B 8B 8B 8B 8B 8B 8B 8B 8B 8B 8B 8B 8B 8B 8B 8B 8B
  81 81 81 81 81 81 81 81
# Small values with the new kernels
V 0A 0A 0A 0A 0A 0A 0A 0A 0A 0A 0A 0A 0A 0A 0A 0A 0A 0A 0A 0A
  0A 0A 0A 0A 0A 0A 0A 0A 0A 0A 0A 0A 0A 0A 0A 0A 0A 0A 0A 0A
  0A 0A 0A 0A 0A 0A 0A 0A
V F6 F6 F6 F6 F6 F6 F6 F6 F6 F6 F6 F6 F6 F6 F6 F6 F6 F6 F6 F6
  F6 F6 F6 F6 F6 F6 F6 F6 F6 F6 F6 F6 F6 F6 F6 F6 F6 F6 F6 F6
  F5 F5 F5 F5 F5 F5 F5 F5
V 00 00 00 00 64 00 00 00 00 64 00 00 00 00 64 00 00 00 00 64
  00 00 00 00 64 00 00 00 00 64 00 00 00 00 64 00 00 00 00 64
  15 15 15 15 15 15 15 15

// File: tests/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter realtime PERIOD = 10ns
) (
    output logic clk
);

    // Free running clock, low at time zero
    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2);
            clk = ~clk;
        end
    end

endmodule

// File: tests/tb_conv_layer.sv
`timescale 1ns/1ps

module tb_conv_layer;

    localparam string PATTERN_FILE = "tests/conv_layer_patterns.txt";

    logic                 clk;
    logic                 arst_n;
    logic                 en;
    conv_pkg::in_frame_t  in_frame;
    logic                 weight_we;
    conv_pkg::weight_wr_t weight_wr;
    logic                 out_valid;
    conv_pkg::out_frame_t out_frame;

    // Expected frames in issue order
    conv_pkg::out_frame_t exp_q [$];
    // Cycle count at which each frame must show on the outputs
    int                   due_q [$];

    int  num_writes;
    int  num_vectors;
    int  pulse_count;
    int  cycle_count;
    int  cycle_limit;
    bit  first_frame_sent;

    tb_clock_gen #(.PERIOD(10ns)) i_clk_gen (.clk(clk));

    conv_layer i_dut (
        .clk       (clk),
        .arst_n    (arst_n),
        .en        (en),
        .in_frame  (in_frame),
        .weight_we (weight_we),
        .weight_wr (weight_wr),
        .out_valid (out_valid),
        .out_frame (out_frame)
    );

    // Ends the run on any failure
    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("Error: %s got 0x%0h expected 0x%0h", name, got, exp));
        end
    endtask

    // First pass counts records so the timeout follows the test length
    task automatic count_records();
        int    fd;
        int    code;
        string tag;
        string rest;
        fd = $fopen(PATTERN_FILE, "r");
        if (fd == 0) begin
            fail_run("could not open the patterns file");
        end
        while (1) begin
            code = $fscanf(fd, "%s", tag);
            if (code != 1) begin
                break;
            end
            // Skip the remainder of every record line
            if (tag == "W") begin
                num_writes++;
            end else if (tag == "V") begin
                num_vectors++;
            end
            if (tag != "V") begin
                code = $fgets(rest, fd);
            end
        end
        $fclose(fd);
    endtask

    // Sample outputs at the falling edge, well away from the clock edge
    always @(negedge clk) begin
        conv_pkg::out_frame_t exp_f;
        int                   due;
        if (!first_frame_sent) begin
            check_value("out_valid", 32'(out_valid), 32'h0);
            check_value("out_frame", 32'(out_frame[31:0]), 32'h0);
            check_value("out_frame", 32'(out_frame[63:32]), 32'h0);
        end
        if (out_valid) begin
            if (exp_q.size() == 0) begin
                fail_run("out_valid pulsed with no frame outstanding");
            end else begin
                exp_f = exp_q.pop_front();
                due   = due_q.pop_front();
                pulse_count++;
                // Two register stages after the edge that took the frame
                check_value("out_valid cycle", 32'(cycle_count), 32'(due));
                for (int o = 0; o < conv_pkg::NUM_OUT_CH; o++) begin
                    check_value($sformatf("out_frame.ch[%0d]", o),
                                32'(out_frame.ch[o]), 32'(exp_f.ch[o]));
                end
            end
        end else if (due_q.size() != 0 && due_q[0] == cycle_count) begin
            // Frame due now but no pulse
            check_value("out_valid", 32'(out_valid), 32'h1);
        end
    end

    // Watchdog
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            fail_run("timeout: outputs stopped arriving");
        end
    end

    initial begin
        int                   fd;
        int                   code;
        int                   seed_dummy;
        int                   gap;
        string                tag;
        string                rest;
        logic [7:0]           b;
        logic [7:0]           oc;
        logic [7:0]           ic;
        conv_pkg::in_frame_t  frame_f;
        conv_pkg::out_frame_t exp_f;

        seed_dummy = $urandom(55603);
        arst_n           = 1'b0;
        en               = 1'b0;
        in_frame         = '0;
        weight_we        = 1'b0;
        weight_wr        = '0;
        num_writes       = 0;
        num_vectors      = 0;
        pulse_count      = 0;
        cycle_count      = 0;
        first_frame_sent = 1'b0;

        count_records();
        // Gaps average 1.5 cycles, 5 per vector leaves margin
        cycle_limit = num_writes + 5 * num_vectors + 50;

        repeat (2) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        fd = $fopen(PATTERN_FILE, "r");
        if (fd == 0) begin
            fail_run("could not open the patterns file");
        end
        while (1) begin
            code = $fscanf(fd, "%s", tag);
            if (code != 1) begin
                break;
            end
            if (tag == "#") begin
                code = $fgets(rest, fd);
            end else if (tag == "W") begin
                code = $fscanf(fd, "%h %h", oc, ic);
                @(negedge clk);
                en                  = 1'b0;
                weight_we           = 1'b1;
                weight_wr.out_ch    = oc[2:0];
                weight_wr.in_ch     = ic[2:0];
                for (int t = 0; t < conv_pkg::NUM_TAPS; t++) begin
                    code = $fscanf(fd, "%h", b);
                    weight_wr.taps.tap[t] = b;
                end
            end else if (tag == "V") begin
                // Gap of 0 to 3 idle cycles, zero often enough for back-to-back runs
                gap = $urandom % 4;
                repeat (gap) begin
                    @(negedge clk);
                    en        = 1'b0;
                    weight_we = 1'b0;
                end
                // Held locally until the previous frame has been sampled
                for (int i = 0; i < conv_pkg::NUM_IN_CH; i++) begin
                    for (int t = 0; t < conv_pkg::NUM_TAPS; t++) begin
                        code = $fscanf(fd, "%h", b);
                        frame_f.ch[i].tap[t] = b;
                    end
                end
                for (int o = 0; o < conv_pkg::NUM_OUT_CH; o++) begin
                    code = $fscanf(fd, "%h", b);
                    exp_f.ch[o] = b;
                end
                if (code != 1) begin
                    fail_run("patterns file ends inside a vector record");
                end
                @(negedge clk);
                weight_we = 1'b0;
                en        = 1'b1;
                in_frame  = frame_f;
                exp_q.push_back(exp_f);
                due_q.push_back(cycle_count + 2);
                first_frame_sent = 1'b1;
            end else begin
                fail_run($sformatf("unknown record type %s in patterns file", tag));
            end
        end
        $fclose(fd);

        @(negedge clk);
        en        = 1'b0;
        weight_we = 1'b0;

        // Drain the pipeline, the watchdog bounds this wait
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        // A few more cycles to catch any stray out_valid
        repeat (4) @(negedge clk);

        if (pulse_count == num_vectors) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            fail_run($sformatf("saw %0d output pulses for %0d frames",
                               pulse_count, num_vectors));
        end
    end

endmodule
